// ==== project.f ====
design/frame_pkg.sv
design/fifo_pkg.sv
design/axis_if.sv
design/frame_checker.sv
design/frame_fifo.sv
design/checksum_stripper.sv
design/frame_rx_top.sv
verif/frame_rx_sva.sv
verif/tb_frame_rx.sv

// ==== Makefile ====
SRCS := $(shell cat project.f)

all: run

obj_dir/Vtb_frame_rx: project.f $(SRCS)
	verilator --binary --timing --assert -f project.f --top-module tb_frame_rx

run: obj_dir/Vtb_frame_rx
	obj_dir/Vtb_frame_rx > sim.log 2>&1; cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== verif/tb_frame_rx.sv ====
`timescale 1ns/1ns

module tb_frame_rx import frame_pkg::*, fifo_pkg::*; ();

  localparam int ready_high = 0;
  localparam int ready_hold = 1;
  localparam int ready_random = 2;
  localparam int ovf_len = fifo_depth / 2 - 1; // Two such frames fit, a third never does.
  localparam int drain_limit = 100; // Far more cycles than the largest backlog needs.

  logic  clk;
  logic  rst;
  byte_t in_data;
  logic  in_valid;
  logic  in_ready;
  logic  in_last;
  byte_t out_data;
  logic  out_valid;
  logic  out_ready;
  logic  out_last;
  logic  bad_frame;
  logic  drop_frame;

  // Frame table columns are length with checksum, corrupt, out_ready mode, kept and gap.
  int len_q[$];
  int corrupt_q[$];
  int mode_q[$];
  int keep_q[$];
  int gap_q[$];

  logic [8:0]  want_q[$]; // Expected {last, data} of each output beat.
  logic [31:0] lfsr_state = 32'hf60849fe;
  int          ready_mode = ready_high;
  logic        edge_ready;
  int          value_errors = 0;
  int          other_errors = 0;
  int          bad_pulses = 0;
  int          drop_cycles = 0;

  frame_rx_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_last    (in_last),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_last   (out_last),
    .bad_frame  (bad_frame),
    .drop_frame (drop_frame)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic byte_t rand_byte();
    byte_t v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      v = {v[6:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // Inputs and out_ready change 1 ns after each rising edge.
  task automatic tick();
    @(posedge clk);
    edge_ready = in_ready;
    #1;
    case (ready_mode)
      ready_hold: out_ready = 1'b0;
      ready_random: out_ready = lfsr_bit();
      default: out_ready = 1'b1;
    endcase
  endtask

  task automatic add_entry(input int len, input int corrupt, input int mode,
                           input int keep, input int gap);
    len_q.push_back(len);
    corrupt_q.push_back(corrupt);
    mode_q.push_back(mode);
    keep_q.push_back(keep);
    gap_q.push_back(gap);
  endtask

  task automatic load_table();
    for (int n = 2; n <= 9; n++) begin
      add_entry(n, 0, ready_high, 1, 3); // Every legal length once.
    end
    add_entry(4, 1, ready_high, 0, 3);
    add_entry(5, 0, ready_high, 1, 3);
    add_entry(7, 1, ready_high, 0, 3);
    add_entry(1, 0, ready_high, 0, 3); // Too short to hold a payload.
    add_entry(ovf_len, 0, ready_hold, 1, 0);
    add_entry(ovf_len, 0, ready_hold, 1, 0);
    add_entry(ovf_len, 0, ready_hold, 0, 0);
    add_entry(ovf_len, 0, ready_hold, 0, 2);
    add_entry(5, 0, ready_high, 1, 3);
    add_entry(6, 0, ready_random, 1, 2);
    add_entry(3, 1, ready_random, 0, 2);
    add_entry(8, 0, ready_random, 1, 2);
    add_entry(2, 0, ready_random, 1, 2);
    add_entry(5, 1, ready_random, 0, 2);
    add_entry(9, 0, ready_random, 1, 2);
    add_entry(4, 0, ready_random, 1, 2);
    add_entry(1, 0, ready_random, 0, 2);
  endtask

  task automatic send_frame(input int idx);
    byte_t bytes[$];
    byte_t sum;
    int    len;
    len = len_q[idx];
    sum = '0;
    for (int i = 0; i < len - 1; i++) begin
      bytes.push_back(rand_byte());
      sum = sum ^ bytes[i];
    end
    if (corrupt_q[idx] != 0) begin
      sum = ~sum;
    end
    if (keep_q[idx] != 0) begin
      foreach (bytes[i]) begin
        want_q.push_back({i == bytes.size() - 1, bytes[i]});
      end
    end
    bytes.push_back(sum);
    for (int i = 0; i < len; i++) begin
      in_data = bytes[i];
      in_last = (i == len - 1);
      in_valid = 1'b1;
      tick();
      while (!edge_ready) begin
        tick();
      end
    end
    in_valid = 1'b0;
    in_last = 1'b0;
  endtask

  // Waits until every expected byte has left or the cycle limit runs out.
  task automatic drain(input int mode);
    int waited;
    ready_mode = (mode == ready_random) ? ready_random : ready_high;
    waited = 0;
    while (want_q.size() != 0 && waited < drain_limit) begin
      tick();
      waited++;
    end
  endtask

  always @(posedge clk) begin
    logic [8:0] want;
    if (!rst) begin
      if (bad_frame) bad_pulses++;
      if (drop_frame) drop_cycles++;
      if (out_valid && out_ready) begin
        if (want_q.size() == 0) begin
          other_errors++;
          $display("Output byte %02h at %0t arrived when no byte was expected", out_data, $time);
        end else begin
          want = want_q.pop_front();
          check_value("out_data", 32'(out_data), 32'(want[7:0]));
          check_value("out_last", 32'(out_last), 32'(want[8]));
        end
      end
    end
  end

  initial begin
    int   expect_bad;
    int   prev_mode;
    int   drops_before;
    logic dropped;
    logic expect_drop;
    rst = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    out_ready = 1'b1;
    load_table();
    expect_bad = 0;
    prev_mode = ready_high;
    repeat (4) begin
      tick();
      check_value("out_valid in reset", 32'(out_valid), 32'd0);
      check_value("bad_frame in reset", 32'(bad_frame), 32'd0);
      check_value("drop_frame in reset", 32'(drop_frame), 32'd0);
    end
    rst = 1'b0;
    tick();
    check_value("in_ready after reset", 32'(in_ready), 32'd1);
    check_value("out_valid after reset", 32'(out_valid), 32'd0);
    for (int e = 0; e < len_q.size(); e++) begin
      if (corrupt_q[e] != 0 || len_q[e] < 2) expect_bad++;
      // Held frames follow each other so the memory fills up.
      if (!(mode_q[e] == ready_hold && prev_mode == ready_hold)) drain(mode_q[e]);
      ready_mode = mode_q[e];
      drops_before = drop_cycles;
      send_frame(e);
      repeat (gap_q[e]) tick();
      dropped = (drop_cycles != drops_before);
      expect_drop = (corrupt_q[e] == 0) && (len_q[e] >= 2) && (keep_q[e] == 0);
      check_value("drop_frame seen", 32'(dropped), 32'(expect_drop));
      prev_mode = mode_q[e];
    end
    drain(ready_high);
    repeat (4) tick();
    check_value("bad_frame pulses", 32'(bad_pulses), 32'(expect_bad));
    check_value("bytes still expected", 32'(want_q.size()), 32'd0);
    $display("Errors: %0d value mismatches, %0d other failures (%0d bad pulses, %0d drop cycles)",
             value_errors, other_errors, bad_pulses, drop_cycles);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (len_q.size() * 200 + 1000) @(posedge clk);
    $display("Timeout: the run did not finish within the cycle limit");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== verif/frame_rx_sva.sv ====
`timescale 1ns/1ns

module frame_rx_sva import frame_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  in_ready,
  input byte_t out_data,
  input logic  out_valid,
  input logic  out_ready,
  input logic  out_last,
  input logic  bad_frame
);

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
    else $error("out_data or out_last changed while the output was stalled");

  a_in_ready: assert property (@(posedge clk) !rst |-> in_ready)
    else $error("in_ready low outside reset");

  a_bad_pulse: assert property (@(posedge clk) disable iff (rst) bad_frame |=> !bad_frame)
    else $error("bad_frame high for two cycles in a row");

  a_reset_valid: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high right after reset");

endmodule

bind frame_rx_top frame_rx_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .in_ready  (in_ready),
  .out_data  (out_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_last  (out_last),
  .bad_frame (bad_frame)
);

// ==== design/frame_rx_top.sv ====
`timescale 1ns/1ns

module frame_rx_top import frame_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  byte_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  input  logic  in_last,
  output byte_t out_data,
  output logic  out_valid,
  input  logic  out_ready,
  output logic  out_last,
  output logic  bad_frame,
  output logic  drop_frame
);

  axis_if chk_if ();
  axis_if fifo_if ();

  frame_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_last   (in_last),
    .m         (chk_if.source),
    .bad_frame (bad_frame)
  );

  frame_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .s          (chk_if.sink),
    .m          (fifo_if.source),
    .drop_frame (drop_frame)
  );

  checksum_stripper u_stripper (
    .clk       (clk),
    .rst       (rst),
    .s         (fifo_if.sink),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last)
  );

endmodule

// ==== design/checksum_stripper.sv ====
`timescale 1ns/1ns

module checksum_stripper import frame_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  axis_if.sink  s,
  output byte_t out_data,
  output logic  out_valid,
  input  logic  out_ready,
  output logic  out_last
);

  typedef enum logic {
    empty,
    holding
  } strip_state_t;

  strip_state_t state;
  byte_t        hold_data; // Byte waiting to learn whether it is the checksum.
  byte_t        out_data_q;
  logic         out_last_q;
  logic         out_valid_q;
  logic         out_free;
  logic         take;

  assign out_free = !out_valid_q || out_ready;

  // An empty hold stage always takes a beat; a full one needs room at the output.
  assign s.ready = (state == empty) || out_free;
  assign take = s.valid && s.ready;

  assign out_data = out_data_q;
  assign out_last = out_last_q;
  assign out_valid = out_valid_q;

  always_ff @(posedge clk) begin
    if (take && state == holding) begin
      out_data_q <= hold_data;
      out_last_q <= s.last; // The checksum beat marks the byte before it.
    end
    if (take && !s.last) begin
      hold_data <= s.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= empty;
      out_valid_q <= 1'b0;
    end else begin
      if (out_valid_q && out_ready) begin
        out_valid_q <= 1'b0;
      end
      if (take) begin
        case (state)
          empty: begin
            // A lone last beat carries no payload.
            state <= s.last ? empty : holding;
          end
          holding: begin
            out_valid_q <= 1'b1;
            state <= s.last ? empty : holding;
          end
          default: state <= empty;
        endcase
      end
    end
  end

endmodule

// ==== design/frame_fifo.sv ====
`timescale 1ns/1ns

module frame_fifo import frame_pkg::*, fifo_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  axis_if.sink   s,
  axis_if.source m,
  output logic   drop_frame
);

  logic [$bits(byte_t):0] mem [fifo_depth]; // Last flag above the byte.

  ptr_t  wr_ptr;     // End of the last committed frame.
  ptr_t  wr_ptr_cur; // Next write position inside the frame being received.
  ptr_t  wr_ptr_rd;  // Committed pointer as the read side sees it, one cycle late.
  ptr_t  rd_ptr;
  addr_t wr_addr;
  addr_t rd_addr;
  logic  beat;
  logic  mem_full;
  logic  mem_empty;
  logic  drop_q;
  logic  reject;
  logic  store;
  logic  read;
  byte_t out_data_q;
  logic  out_last_q;
  logic  out_valid_q;

  // Frames that do not fit are dropped, so the input never stalls.
  assign s.ready = 1'b1;

  assign beat = s.valid && s.ready;
  assign wr_addr = wr_ptr_cur[fifo_addr_width-1:0];
  assign rd_addr = rd_ptr[fifo_addr_width-1:0];
  assign mem_full = (wr_ptr_cur - rd_ptr) == ptr_t'(fifo_depth);
  assign mem_empty = (wr_ptr_rd == rd_ptr);

  // Once a beat is rejected the rest of that frame goes too.
  assign reject = beat && (drop_q || mem_full);
  assign store = beat && !drop_q && !mem_full;
  assign drop_frame = drop_q || reject;

  assign read = !mem_empty && (!out_valid_q || m.ready);

  assign m.data = out_data_q;
  assign m.last = out_last_q;
  assign m.valid = out_valid_q;
  assign m.user = 1'b0; // Only good frames are ever committed.

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_addr] <= {s.last, s.data};
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      {out_last_q, out_data_q} <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      wr_ptr_cur <= '0;
      wr_ptr_rd <= '0;
      rd_ptr <= '0;
      drop_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      wr_ptr_rd <= wr_ptr;
      if (reject) begin
        drop_q <= !s.last;
        if (s.last) begin
          wr_ptr_cur <= wr_ptr; // Roll back the partial frame.
        end
      end else if (store) begin
        wr_ptr_cur <= wr_ptr_cur + ptr_t'(1);
        if (s.last) begin
          if (s.user) begin
            wr_ptr_cur <= wr_ptr;
          end else begin
            wr_ptr <= wr_ptr_cur + ptr_t'(1); // Commit the frame.
          end
        end
      end
      if (read) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
        out_valid_q <= 1'b1;
      end else if (m.ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

endmodule

// ==== design/frame_checker.sv ====
`timescale 1ns/1ns

module frame_checker import frame_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  byte_t  in_data,
  input  logic   in_valid,
  output logic   in_ready,
  input  logic   in_last,
  axis_if.source m,
  output logic   bad_frame
);

  byte_t xor_acc;
  byte_t xor_next;
  len_t  byte_cnt;
  len_t  cnt_next;
  logic  fire;

  assign xor_next = xor_acc ^ in_data; // Zero over a whole good frame.
  assign cnt_next = (byte_cnt == '1) ? byte_cnt : byte_cnt + len_t'(1);
  assign fire = in_valid && m.ready;

  // The stream passes straight through to the buffer.
  assign m.data = in_data;
  assign m.valid = in_valid;
  assign m.last = in_last;
  assign in_ready = m.ready;

  // Flag the frame on its last beat when the checksum fails or it is too short.
  assign m.user = in_last && ((xor_next != '0) || (cnt_next < len_t'(min_frame_len)));

  always_ff @(posedge clk) begin
    if (rst) begin
      xor_acc <= '0;
      byte_cnt <= '0;
      bad_frame <= 1'b0;
    end else begin
      bad_frame <= fire && m.user; // One pulse per flagged frame.
      if (fire) begin
        if (in_last) begin
          xor_acc <= '0;
          byte_cnt <= '0;
        end else begin
          xor_acc <= xor_next;
          byte_cnt <= cnt_next;
        end
      end
    end
  end

endmodule

// ==== design/axis_if.sv ====
`timescale 1ns/1ns

interface axis_if import frame_pkg::*; ();

  byte_t data;
  logic  valid;
  logic  ready;
  logic  last;
  logic  user; // Bad frame flag, only meaningful together with last.

  modport source (
    output data,
    output valid,
    output last,
    output user,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    input  user,
    output ready
  );

endinterface

// ==== design/fifo_pkg.sv ====
package fifo_pkg;

  localparam int fifo_addr_width = 4;
  localparam int fifo_depth = 16;

  // Index into the frame memory.
  typedef logic [fifo_addr_width-1:0] addr_t;

  // Memory index plus a wrap bit, so full and empty can be told apart.
  typedef logic [fifo_addr_width:0] ptr_t;

endpackage

// ==== design/frame_pkg.sv ====
package frame_pkg;

  // One byte of a frame, payload or checksum.
  typedef logic [7:0] byte_t;

  // Byte count within a frame. It saturates on very long frames.
  typedef logic [7:0] len_t;

  // One payload byte followed by the checksum.
  localparam int min_frame_len = 2;

endpackage
